//--- src/fm_cfg_pkg.sv
`default_nettype none

package fm_cfg_pkg;

    localparam int num_ch           = 6;
    localparam int num_slot         = 24;  // 6 channels x 4 operators
    localparam int busy_ticks       = 32;  // synthesis ticks per data write
    localparam int timer_b_prescale = 16;  // ticks per timer B count

    // register numbers as written by the host on an address write
    typedef enum logic [7:0] {
        reg_timer_a_hi = 8'h24,
        reg_timer_a_lo = 8'h25,
        reg_timer_b    = 8'h26,
        reg_timer_ctl  = 8'h27,
        reg_keyon      = 8'h28,
        reg_div6       = 8'h2D,
        reg_div3       = 8'h2E,
        reg_div2       = 8'h2F,
        reg_dt_mul     = 8'h30,  // operator groups, low nibble picks op and channel
        reg_tl         = 8'h40,
        reg_ks_ar      = 8'h50,
        reg_fnum_lo    = 8'hA0,  // channel groups, low two bits pick channel
        reg_fnum_hi    = 8'hA4,
        reg_fb_alg     = 8'hB0
    } fm_reg_e;

    // prescaler ratio from cen to the synthesis tick
    typedef enum logic [1:0] {
        div_by_6,
        div_by_3,
        div_by_2
    } div_e;

endpackage

`default_nettype wire

//--- src/fm_bus_pkg.sv
`default_nettype none

package fm_bus_pkg;

    // one-hot update strobes
    typedef struct packed {
        logic keyon;
        logic dt_mul;
        logic tl;
        logic ks_ar;
        logic fnum_lo;
        logic fb_alg;
    } upd_t;

    typedef struct packed {
        logic [2:0] ch;       // {part, reg[1:0]}
        logic [1:0] op;       // reg[3:2]
        logic [7:0] data;
        upd_t       upd;
        logic       latch_hi; // A4h write, loads the shared block/fnum-high latch
    } host_wr_t;

    typedef struct packed {
        logic [9:0] value_a;
        logic [7:0] value_b;
        logic       load_a;
        logic       load_b;
        logic       irq_en_a;
        logic       irq_en_b;
        logic       clr_a;
        logic       clr_b;
    } timer_ctl_t;

    // parameters of one slot as played out to the operator pipeline
    typedef struct packed {
        logic [4:0]  idx;
        logic        keyon;
        logic [2:0]  dt;
        logic [3:0]  mul;
        logic [6:0]  tl;
        logic [1:0]  ks;
        logic [4:0]  ar;
        logic [10:0] fnum;
        logic [2:0]  block;
        logic [2:0]  fb;
        logic [2:0]  alg;
    } slot_param_t;

endpackage

`default_nettype wire

//--- src/fm_clk_div.sv
`default_nettype none

module fm_clk_div import fm_cfg_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic cen,
    input  div_e div_sel,
    output logic clk_en
);

    logic [2:0] cnt;
    logic [2:0] last;  // terminal count for the selected ratio

    always_comb begin
        case (div_sel)
            div_by_3: last = 3'd2;
            div_by_2: last = 3'd1;
            default:  last = 3'd5;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt    <= 3'd0;
            clk_en <= 1'b0;
        end else begin
            clk_en <= 1'b0;
            if (cen) begin
                // >= so a ratio change mid-count cannot overrun
                if (cnt >= last) begin
                    cnt    <= 3'd0;
                    clk_en <= 1'b1;
                end else begin
                    cnt <= cnt + 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/fm_mmr.sv
`default_nettype none

module fm_mmr import fm_cfg_pkg::*, fm_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       write,
    input  logic [1:0] addr,
    input  logic [7:0] din,
    input  logic       clk_en,
    output div_e       div_sel,
    output host_wr_t   wr,
    output timer_ctl_t tctl,
    output logic       busy
);

    fm_reg_e    sel_reg;  // register number from the last address write
    logic       part;
    logic       write_d;
    logic       wr_rise;
    logic       data_wr;

    upd_t       upd_q;
    logic       latch_q;
    logic [2:0] ch_q;
    logic [1:0] op_q;
    logic [7:0] data_q;

    logic [$clog2(busy_ticks)-1:0] busy_cnt;

    assign wr_rise = write & ~write_d;
    assign data_wr = wr_rise & addr[0];

    assign wr = '{ch: ch_q, op: op_q, data: data_q, upd: upd_q, latch_hi: latch_q};

    always_ff @(posedge clk) begin
        if (rst) begin
            write_d <= 1'b0;
            sel_reg <= fm_reg_e'(8'h00);
            part    <= 1'b0;
            div_sel <= div_by_6;
            tctl    <= '0;
            upd_q   <= '0;
            latch_q <= 1'b0;
        end else begin
            write_d <= write;
            upd_q   <= '0;    // strobes last one clock
            latch_q <= 1'b0;
            if (clk_en) begin
                tctl.clr_a <= 1'b0;
                tctl.clr_b <= 1'b0;
            end
            if (wr_rise && !addr[0]) begin
                sel_reg <= fm_reg_e'(din);
                part    <= addr[1];
            end
            if (data_wr) begin
                case (sel_reg)
                    reg_timer_a_hi: tctl.value_a[9:2] <= din;
                    reg_timer_a_lo: tctl.value_a[1:0] <= din[1:0];
                    reg_timer_b:    tctl.value_b <= din;
                    reg_timer_ctl: begin
                        {tctl.clr_b, tctl.clr_a, tctl.irq_en_b, tctl.irq_en_a,
                         tctl.load_b, tctl.load_a} <= din[5:0];
                    end
                    reg_div6: div_sel <= div_by_6;
                    reg_div3: div_sel <= div_by_3;
                    reg_div2: div_sel <= div_by_2;
                    default: ;
                endcase

                // channel 3 of each part does not exist
                if (sel_reg == reg_keyon) begin
                    upd_q.keyon <= 1'b1;
                end else if (sel_reg[1:0] != 2'b11) begin
                    if (sel_reg[7:4] == reg_dt_mul[7:4])
                        upd_q.dt_mul <= 1'b1;
                    else if (sel_reg[7:4] == reg_tl[7:4])
                        upd_q.tl <= 1'b1;
                    else if (sel_reg[7:4] == reg_ks_ar[7:4])
                        upd_q.ks_ar <= 1'b1;
                    else if (sel_reg[7:2] == reg_fnum_lo[7:2])
                        upd_q.fnum_lo <= 1'b1;
                    else if (sel_reg[7:2] == reg_fnum_hi[7:2])
                        latch_q <= 1'b1;
                    else if (sel_reg[7:2] == reg_fb_alg[7:2])
                        upd_q.fb_alg <= 1'b1;
                end
            end
        end
    end

    // write payload, held until the next data write
    always_ff @(posedge clk) begin
        if (data_wr) begin
            data_q <= din;
            ch_q   <= {part, sel_reg[1:0]};
            op_q   <= sel_reg[3:2];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            busy_cnt <= '0;
        end else if (data_wr) begin
            busy     <= 1'b1;  // restarts on every data write
            busy_cnt <= '0;
        end else if (clk_en && busy) begin
            if (busy_cnt == ($bits(busy_cnt))'(busy_ticks - 1))
                busy <= 1'b0;
            busy_cnt <= busy_cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- src/fm_reg_store.sv
`default_nettype none

module fm_reg_store import fm_cfg_pkg::*, fm_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        clk_en,
    input  host_wr_t    wr,
    output slot_param_t slot
);

    // slot = op * num_ch + channel
    function automatic logic [4:0] slot_of(input logic [2:0] chn, input logic [1:0] op);
        return 5'(op) * 5'(num_ch) + 5'(chn);
    endfunction

    // {part, low2} to 0..5
    function automatic logic [2:0] ch_index(input logic [2:0] ch);
        return ch[2] ? 3'(ch[1:0]) + 3'd3 : 3'(ch[1:0]);
    endfunction

    logic [6:0]  dt_mul_mem [num_slot];
    logic [6:0]  tl_mem     [num_slot];
    logic [6:0]  ks_ar_mem  [num_slot];  // {ks, ar}
    logic [10:0] fnum_mem   [num_ch];
    logic [2:0]  block_mem  [num_ch];
    logic [5:0]  fb_alg_mem [num_ch];
    logic [num_slot-1:0] kon;
    logic [5:0]  hi_latch;                // one latch shared by all channels

    logic [2:0]  wr_chn;
    logic [4:0]  wr_slot;
    logic [2:0]  kon_chn;
    logic        kon_ok;

    logic [2:0]  rd_chn;
    logic [1:0]  rd_op;
    logic [2:0]  nxt_chn;
    logic [1:0]  nxt_op;
    logic [4:0]  nxt_idx;
    slot_param_t nxt_p;

    assign wr_chn  = ch_index(wr.ch);
    assign wr_slot = slot_of(wr_chn, wr.op);
    assign kon_chn = ch_index(wr.data[2:0]);
    assign kon_ok  = wr.upd.keyon && (wr.data[1:0] != 2'b11);

    always_ff @(posedge clk) begin
        if (wr.upd.dt_mul) dt_mul_mem[wr_slot] <= wr.data[6:0];
        if (wr.upd.tl)     tl_mem[wr_slot]     <= wr.data[6:0];
        if (wr.upd.ks_ar)  ks_ar_mem[wr_slot]  <= {wr.data[7:6], wr.data[4:0]};
        if (wr.upd.fnum_lo) begin
            fnum_mem[wr_chn]  <= {hi_latch[2:0], wr.data};
            block_mem[wr_chn] <= hi_latch[5:3];
        end
        if (wr.upd.fb_alg) fb_alg_mem[wr_chn] <= wr.data[5:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            kon      <= '0;
            hi_latch <= '0;
        end else begin
            if (wr.latch_hi)
                hi_latch <= wr.data[5:0];
            if (kon_ok)
                for (int k = 0; k < 4; k++)
                    kon[slot_of(kon_chn, 2'(k))] <= wr.data[4 + k];
        end
    end

    // rotation, channels inside operators
    assign nxt_chn = (rd_chn == 3'(num_ch - 1)) ? 3'd0 : rd_chn + 3'd1;
    assign nxt_op  = (rd_chn == 3'(num_ch - 1)) ? rd_op + 2'd1 : rd_op;
    assign nxt_idx = slot_of(nxt_chn, nxt_op);

    always_comb begin
        nxt_p.idx           = nxt_idx;
        nxt_p.keyon         = kon[nxt_idx];
        {nxt_p.dt, nxt_p.mul} = dt_mul_mem[nxt_idx];
        nxt_p.tl            = tl_mem[nxt_idx];
        {nxt_p.ks, nxt_p.ar}  = ks_ar_mem[nxt_idx];
        nxt_p.fnum          = fnum_mem[nxt_chn];
        nxt_p.block         = block_mem[nxt_chn];
        {nxt_p.fb, nxt_p.alg} = fb_alg_mem[nxt_chn];
        // forward a write landing on the slot being read
        if (wr_slot == nxt_idx) begin
            if (wr.upd.dt_mul) {nxt_p.dt, nxt_p.mul} = wr.data[6:0];
            if (wr.upd.tl)     nxt_p.tl = wr.data[6:0];
            if (wr.upd.ks_ar)  {nxt_p.ks, nxt_p.ar} = {wr.data[7:6], wr.data[4:0]};
        end
        if (wr_chn == nxt_chn) begin
            if (wr.upd.fnum_lo) {nxt_p.block, nxt_p.fnum} = {hi_latch, wr.data};
            if (wr.upd.fb_alg)  {nxt_p.fb, nxt_p.alg} = wr.data[5:0];
        end
        if (kon_ok && kon_chn == nxt_chn)
            nxt_p.keyon = wr.data[4 + nxt_op];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_chn <= 3'(num_ch - 1);  // first tick reads slot 0
            rd_op  <= 2'd3;
            slot   <= '0;
        end else if (clk_en) begin
            rd_chn <= nxt_chn;
            rd_op  <= nxt_op;
            slot   <= nxt_p;
        end
    end

endmodule

`default_nettype wire

//--- src/fm_timers.sv
`default_nettype none

module fm_timers import fm_cfg_pkg::*, fm_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       clk_en,
    input  timer_ctl_t tctl,
    output logic       flag_a,
    output logic       flag_b,
    output logic       irq_n
);

    logic [9:0] cnt_a;
    logic [7:0] cnt_b;
    logic [$clog2(timer_b_prescale)-1:0] pre_b;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_a  <= '0;
            cnt_b  <= '0;
            pre_b  <= '0;
            flag_a <= 1'b0;
            flag_b <= 1'b0;
        end else begin
            if (tctl.clr_a) flag_a <= 1'b0;
            if (tctl.clr_b) flag_b <= 1'b0;
            if (clk_en) begin
                // timer A, one count per tick
                if (!tctl.load_a) begin
                    cnt_a <= tctl.value_a;      // held at the start value
                end else if (cnt_a == 10'h3ff) begin
                    cnt_a  <= tctl.value_a;
                    flag_a <= 1'b1;             // wins over a pending clear
                end else begin
                    cnt_a <= cnt_a + 10'd1;
                end

                // timer B, prescaler restarts with the load
                if (!tctl.load_b) begin
                    cnt_b <= tctl.value_b;
                    pre_b <= '0;
                end else begin
                    pre_b <= pre_b + 1'b1;
                    if (pre_b == ($bits(pre_b))'(timer_b_prescale - 1)) begin
                        if (cnt_b == 8'hff) begin
                            cnt_b  <= tctl.value_b;
                            flag_b <= 1'b1;
                        end else begin
                            cnt_b <= cnt_b + 8'd1;
                        end
                    end
                end
            end
        end
    end

    assign irq_n = ~((flag_a & tctl.irq_en_a) | (flag_b & tctl.irq_en_b));

endmodule

`default_nettype wire

//--- src/fm_regs.sv
`default_nettype none

module fm_regs import fm_cfg_pkg::*, fm_bus_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic        write,
    input  logic [1:0]  addr,
    input  logic [7:0]  din,
    output logic        busy,
    output logic        irq_n,
    output logic        flag_a,
    output logic        flag_b,
    output logic        clk_en,
    output slot_param_t slot
);

    div_e       div_sel;
    host_wr_t   wr;
    timer_ctl_t tctl;

    fm_clk_div u_div (
        .clk     (clk),
        .rst     (rst),
        .cen     (cen),
        .div_sel (div_sel),
        .clk_en  (clk_en)
    );

    fm_mmr u_mmr (
        .clk     (clk),
        .rst     (rst),
        .write   (write),
        .addr    (addr),
        .din     (din),
        .clk_en  (clk_en),
        .div_sel (div_sel),
        .wr      (wr),
        .tctl    (tctl),
        .busy    (busy)
    );

    fm_reg_store u_store (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .wr     (wr),
        .slot   (slot)
    );

    fm_timers u_timers (
        .clk    (clk),
        .rst    (rst),
        .clk_en (clk_en),
        .tctl   (tctl),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .irq_n  (irq_n)
    );

endmodule

`default_nettype wire

//--- tb/fm_regs_tb.sv
`default_nettype none

module fm_regs_tb import fm_cfg_pkg::*, fm_bus_pkg::*; ();

    localparam int max_ratio     = 6;
    localparam int n_writes      = 200;                   // host writes in the run, rounded up
    localparam int write_cycles  = 2 * (2 + max_ratio);   // address and data, a tick gap each
    localparam int n_rotations   = 10;
    localparam int timer_b_ticks = 2 * timer_b_prescale;  // longest timer test, 254 to overflow
    localparam int n_ticks       = n_rotations * num_slot + 3 * busy_ticks + 4 * timer_b_ticks;
    localparam int max_cycles    = n_writes * write_cycles + n_ticks * (max_ratio + 1) + 1000;

    logic        clk;
    logic        rst;
    logic        cen;
    logic        write;
    logic [1:0]  addr;
    logic [7:0]  din;
    logic        busy;
    logic        irq_n;
    logic        flag_a;
    logic        flag_b;
    logic        clk_en;
    slot_param_t slot;

    integer seed;
    int     cycles;

    // reference model of the register state
    logic [6:0]  exp_dt_mul [num_slot];
    logic [6:0]  exp_tl     [num_slot];
    logic [6:0]  exp_ks_ar  [num_slot];
    logic        exp_kon    [num_slot];
    logic [10:0] exp_fnum   [num_ch];
    logic [2:0]  exp_block  [num_ch];
    logic [5:0]  exp_fb_alg [num_ch];
    logic [5:0]  exp_latch;              // shared A4h latch
    logic [9:0]  exp_value_a;
    logic [7:0]  exp_value_b;
    int          exp_ratio;

    fm_regs DUT (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .write  (write),
        .addr   (addr),
        .din    (din),
        .busy   (busy),
        .irq_n  (irq_n),
        .flag_a (flag_a),
        .flag_b (flag_b),
        .clk_en (clk_en),
        .slot   (slot)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == max_cycles)
            fail_run($sformatf("Timeout after %0d cycles with tests still running", max_cycles));
    end

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else
            fail_run($sformatf("Mismatch %s got 'h%0h expected 'h%0h", name, got, exp));
    endtask

    // one clock, then settle just after the edge
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_tick();
        while (!clk_en)
            step();
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    task automatic write_addr(input logic part, input logic [7:0] regn);
        write = 1'b1;
        addr  = {part, 1'b0};
        din   = regn;
        step();
        write = 1'b0;
    endtask

    task automatic write_data(input logic part, input logic [7:0] data);
        write = 1'b1;
        addr  = {part, 1'b1};
        din   = data;
        step();
        write = 1'b0;
    endtask

    // host writes at most once per synthesis tick
    task automatic space_write();
        wait_tick();
        step();
    endtask

    task automatic model_write(input logic part, input logic [7:0] regn, input logic [7:0] data);
        int ch;
        int s;
        int kc;
        ch = (part ? 3 : 0) + regn[1:0];
        s  = regn[3:2] * num_ch + ch;
        kc = (data[2] ? 3 : 0) + data[1:0];
        if (regn == 8'h24) begin
            exp_value_a[9:2] = data;
        end else if (regn == 8'h25) begin
            exp_value_a[1:0] = data[1:0];
        end else if (regn == 8'h26) begin
            exp_value_b = data;
        end else if (regn == 8'h28) begin
            if (data[1:0] != 2'b11)
                for (int k = 0; k < 4; k++)
                    exp_kon[k * num_ch + kc] = data[4 + k];
        end else if (regn == 8'h2D) begin
            exp_ratio = 6;
        end else if (regn == 8'h2E) begin
            exp_ratio = 3;
        end else if (regn == 8'h2F) begin
            exp_ratio = 2;
        end else if (regn[1:0] != 2'b11) begin
            if (regn[7:4] == 4'h3)
                exp_dt_mul[s] = data[6:0];
            else if (regn[7:4] == 4'h4)
                exp_tl[s] = data[6:0];
            else if (regn[7:4] == 4'h5)
                exp_ks_ar[s] = {data[7:6], data[4:0]};
            else if ({regn[7:2], 2'b00} == 8'hA0) begin
                exp_fnum[ch]  = {exp_latch[2:0], data};
                exp_block[ch] = exp_latch[5:3];
            end else if ({regn[7:2], 2'b00} == 8'hA4)
                exp_latch = data[5:0];
            else if ({regn[7:2], 2'b00} == 8'hB0)
                exp_fb_alg[ch] = data[5:0];
        end
    endtask

    task automatic host_write(input logic part, input logic [7:0] regn, input logic [7:0] data);
        write_addr(part, regn);
        space_write();
        write_data(part, data);
        space_write();
        model_write(part, regn, data);
    endtask

    task automatic measure_spacing(output int n);
        wait_tick();
        step();
        n = 1;
        while (!clk_en) begin
            step();
            n++;
        end
    endtask

    // one full pass of the slot rotation against the model
    task automatic check_rotation();
        int idx;
        int prev;
        int ch;
        slot_param_t s;
        prev = -1;
        for (int n = 0; n < num_slot; n++) begin
            wait_tick();
            step();
            s   = slot;
            idx = s.idx;
            assert (idx < num_slot) else fail_run("Slot index left the 24-slot range");
            if (prev >= 0)
                expect_eq("slot.idx", s.idx, (prev + 1) % num_slot);
            ch = idx % num_ch;
            expect_eq("slot.keyon", s.keyon, exp_kon[idx]);
            expect_eq("slot.dt_mul", {s.dt, s.mul}, exp_dt_mul[idx]);
            expect_eq("slot.tl", s.tl, exp_tl[idx]);
            expect_eq("slot.ks_ar", {s.ks, s.ar}, exp_ks_ar[idx]);
            expect_eq("slot.fnum", s.fnum, exp_fnum[ch]);
            expect_eq("slot.block", s.block, exp_block[ch]);
            expect_eq("slot.fb_alg", {s.fb, s.alg}, exp_fb_alg[ch]);
            prev = idx;
        end
    endtask

    initial begin
        int         n;
        logic [7:0] d;
        seed  = 32'h1812;
        rst   = 1'b1;
        cen   = 1'b1;
        write = 1'b0;
        addr  = 2'b00;
        din   = 8'h00;
        for (int i = 0; i < num_slot; i++) begin
            exp_dt_mul[i] = '0;
            exp_tl[i]     = '0;
            exp_ks_ar[i]  = '0;
            exp_kon[i]    = 1'b0;
        end
        for (int i = 0; i < num_ch; i++) begin
            exp_fnum[i]   = '0;
            exp_block[i]  = '0;
            exp_fb_alg[i] = '0;
        end
        exp_latch   = '0;
        exp_value_a = '0;
        exp_value_b = '0;
        exp_ratio   = 6;

        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        step();
        expect_eq("busy", busy, 0);
        expect_eq("irq_n", irq_n, 1);

        // divider ratio
        measure_spacing(n);
        expect_eq("clk_en spacing", n, exp_ratio);
        host_write(1'b0, 8'h2E, 8'h00);
        measure_spacing(n);
        expect_eq("clk_en spacing", n, exp_ratio);
        host_write(1'b0, 8'h2F, 8'h00);
        measure_spacing(n);
        expect_eq("clk_en spacing", n, exp_ratio);

        // fill every operator and channel entry
        for (int g = 3; g <= 5; g++)
            for (int p = 0; p < 2; p++)
                for (int j = 0; j < 16; j++)
                    if (j[1:0] != 2'b11)
                        host_write(p[0], {4'(g), 4'(j)}, rand_byte());
        for (int p = 0; p < 2; p++)
            for (int c = 0; c < 3; c++) begin
                host_write(p[0], 8'hA4 + 8'(c), rand_byte());
                host_write(p[0], 8'hA0 + 8'(c), rand_byte());
                host_write(p[0], 8'hB0 + 8'(c), rand_byte());
            end
        check_rotation();

        // random operator writes, low bits 3 included
        for (int i = 0; i < 24; i++) begin
            d = rand_byte();
            host_write(d[0], {4'(3 + {$random(seed)} % 3), d[7:4]}, rand_byte());
        end
        check_rotation();

        // fnum and block through the latch
        host_write(1'b1, 8'hA5, 8'h2D);
        host_write(1'b1, 8'hA1, rand_byte());
        check_rotation();
        host_write(1'b0, 8'hA6, 8'h3F);  // latch only, no commit
        check_rotation();

        // key on and off per operator
        for (int c = 0; c < 8; c++) begin
            d = rand_byte();
            host_write(1'b0, 8'h28, {d[7:4], 1'b0, 3'(c)});
        end
        host_write(1'b0, 8'h28, 8'hF3);  // no channel 3
        host_write(1'b0, 8'h28, 8'hF7);
        check_rotation();
        for (int c = 0; c < 8; c++)
            host_write(1'b0, 8'h28, {5'b0, 3'(c)});
        check_rotation();

        // busy window
        while (busy)
            step();
        write_addr(1'b0, 8'h41);
        space_write();
        expect_eq("busy", busy, 0);
        d = rand_byte();
        write_data(1'b0, d);
        model_write(1'b0, 8'h41, d);
        expect_eq("busy", busy, 1);
        n = 0;
        while (n < busy_ticks) begin
            if (clk_en)
                n++;                   // taken on the next edge
            step();
            expect_eq("busy", busy, n < busy_ticks);
        end

        // timer A from 1020, irq masked first
        host_write(1'b0, 8'h24, 8'hFF);
        host_write(1'b0, 8'h25, 8'h00);
        write_addr(1'b0, 8'h27);
        space_write();
        write_data(1'b0, 8'h01);
        n = 0;
        while (!flag_a) begin
            if (clk_en)
                n++;
            step();
            assert (n <= 1024 - exp_value_a) else
                fail_run("Timer A did not raise flag_a after its overflow");
        end
        expect_eq("irq_n", irq_n, 1);
        host_write(1'b0, 8'h27, 8'h05);
        expect_eq("irq_n", irq_n, 0);
        host_write(1'b0, 8'h27, 8'h14);  // clear with the irq still enabled
        expect_eq("flag_a", flag_a, 0);
        expect_eq("irq_n", irq_n, 1);

        // timer B from 254
        host_write(1'b0, 8'h26, 8'd254);
        write_addr(1'b0, 8'h27);
        space_write();
        write_data(1'b0, 8'h0A);
        n = 0;
        while (!flag_b) begin
            if (clk_en)
                n++;
            step();
            assert (n <= (256 - exp_value_b) * timer_b_prescale) else
                fail_run("Timer B did not raise flag_b after its overflow");
        end
        expect_eq("irq_n", irq_n, 0);
        host_write(1'b0, 8'h27, 8'h28);
        expect_eq("flag_b", flag_b, 0);
        expect_eq("irq_n", irq_n, 1);

        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- fm_regs.f
src/fm_cfg_pkg.sv
src/fm_bus_pkg.sv
src/fm_clk_div.sv
src/fm_mmr.sv
src/fm_reg_store.sv
src/fm_timers.sv
src/fm_regs.sv
tb/fm_regs_tb.sv

//--- Bender.yml
package:
  name: fm_regs

sources:
  - src/fm_cfg_pkg.sv
  - src/fm_bus_pkg.sv
  - src/fm_clk_div.sv
  - src/fm_mmr.sv
  - src/fm_reg_store.sv
  - src/fm_timers.sv
  - src/fm_regs.sv
  - target: test
    files:
      - tb/fm_regs_tb.sv
